/* cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [7:0] opcode_t;

    // Standard 6502 opcode values
    localparam opcode_t OP_NOP     = 8'hEA;
    localparam opcode_t OP_SEC     = 8'h38;
    localparam opcode_t OP_CLC     = 8'h18;
    localparam opcode_t OP_CLV     = 8'hB8;
    localparam opcode_t OP_TAX     = 8'hAA;
    localparam opcode_t OP_TAY     = 8'hA8;
    localparam opcode_t OP_TXA     = 8'h8A;
    localparam opcode_t OP_TYA     = 8'h98;
    localparam opcode_t OP_LDA_IMM = 8'hA9;
    localparam opcode_t OP_LDX_IMM = 8'hA2;
    localparam opcode_t OP_LDY_IMM = 8'hA0;
    localparam opcode_t OP_LDA_ZPG = 8'hA5;
    localparam opcode_t OP_LDA_ABS = 8'hAD;
    localparam opcode_t OP_LDX_ZPG = 8'hA6;
    localparam opcode_t OP_LDX_ABS = 8'hAE;
    localparam opcode_t OP_LDY_ZPG = 8'hA4;
    localparam opcode_t OP_LDY_ABS = 8'hAC;
    localparam opcode_t OP_STA_ZPG = 8'h85;
    localparam opcode_t OP_STA_ABS = 8'h8D;
    localparam opcode_t OP_STX_ZPG = 8'h86;
    localparam opcode_t OP_STX_ABS = 8'h8E;
    localparam opcode_t OP_STY_ZPG = 8'h84;
    localparam opcode_t OP_STY_ABS = 8'h8C;
    localparam opcode_t OP_ASL_A   = 8'h0A;
    localparam opcode_t OP_LSR_A   = 8'h4A;
    localparam opcode_t OP_ROL_A   = 8'h2A;
    localparam opcode_t OP_ROR_A   = 8'h6A;
    localparam opcode_t OP_INX     = 8'hE8;
    localparam opcode_t OP_INY     = 8'hC8;
    localparam opcode_t OP_DEX     = 8'hCA;
    localparam opcode_t OP_DEY     = 8'h88;
    localparam opcode_t OP_AND_ZPG = 8'h25;
    localparam opcode_t OP_AND_ABS = 8'h2D;
    localparam opcode_t OP_ORA_ZPG = 8'h05;
    localparam opcode_t OP_ORA_ABS = 8'h0D;
    localparam opcode_t OP_EOR_ZPG = 8'h45;
    localparam opcode_t OP_EOR_ABS = 8'h4D;
    localparam opcode_t OP_ADC_ZPG = 8'h65;
    localparam opcode_t OP_ADC_ABS = 8'h6D;
    localparam opcode_t OP_SBC_ZPG = 8'hE5;
    localparam opcode_t OP_SBC_ABS = 8'hED;
    localparam opcode_t OP_JMP_ABS = 8'h4C;

    typedef enum logic [1:0] {AM_IMP, AM_IMM, AM_ZPG, AM_ABS} addr_mode_t;

    typedef enum logic [2:0] {
        CL_FLAG, CL_XFER, CL_REG_ALU, CL_LOAD, CL_STORE, CL_MEM_ALU, CL_JUMP, CL_UNKNOWN
    } op_class_t;

    typedef enum logic [1:0] {REG_NONE, REG_A, REG_X, REG_Y} reg_sel_t;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_AND, ALU_OR, ALU_XOR,
        ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC,
        ALU_FLG, // Flags from the value passing through
        ALU_TMX  // Result out of the ALU
    } alu_op_t;

    typedef logic [7:0] flag_mask_t;

    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_V = 6;
    localparam int FLAG_N = 7;

    localparam flag_mask_t MASK_CZN = flag_mask_t'((1 << FLAG_C) | (1 << FLAG_Z) | (1 << FLAG_N));
    localparam flag_mask_t MASK_ZN  = flag_mask_t'((1 << FLAG_Z) | (1 << FLAG_N));

endpackage

/* cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    localparam int ADDR_W        = 16;
    localparam int OPERAND_CNT_W = 2;

    typedef enum logic [3:0] {
        S_IDLE,
        S_OPCODE_READ,
        S_OPERAND_FETCH, // One cycle per operand byte
        S_DATA_LATCH,
        S_ALU_FINAL,
        S_ALU_TMX,
        S_DBUF_OUTPUT,
        S_PC_LOAD
    } fsm_state_t;

    typedef enum logic [1:0] {
        BUF2_IDLE  = 2'b00,
        BUF2_LOAD  = 2'b01,
        BUF2_STORE = 2'b10
    } buf2_t;

    // Bit 2 enable, bit 1 register takes the bus, bit 0 bus select
    typedef enum logic [2:0] {
        BUF3_IDLE   = 3'b000,
        BUF3_LOAD1  = 3'b110,
        BUF3_LOAD2  = 3'b111,
        BUF3_STORE1 = 3'b100,
        BUF3_STORE2 = 3'b101
    } buf3_t;

    typedef enum logic [1:0] {PC_HOLD = 2'b00, PC_INC = 2'b01, PC_LOAD = 2'b10} pc_ctrl_t;

    typedef enum logic [1:0] {ADDR_PC = 2'b00, ADDR_MEM = 2'b01} addr_sel_t;

endpackage

/* opcode_decoder.sv */
`timescale 1ns/1ns

module opcode_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clk_enable,
    input  logic                   capture_opcode,
    input  cpu_isa_pkg::opcode_t    instruction,
    output cpu_isa_pkg::addr_mode_t addr_mode,
    output cpu_isa_pkg::op_class_t  op_class,
    output cpu_isa_pkg::reg_sel_t   src_reg,
    output cpu_isa_pkg::reg_sel_t   dst_reg,
    output cpu_isa_pkg::alu_op_t    alu_op,
    output cpu_isa_pkg::flag_mask_t flag_mask,
    output cpu_isa_pkg::flag_mask_t flag_value
);
    import cpu_isa_pkg::*;

    opcode_t opcode;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode <= OP_NOP;
        end else if (clk_enable && capture_opcode) begin
            opcode <= instruction;
        end
    end

    // Class, registers and flag effects
    always_comb begin
        op_class   = CL_UNKNOWN;
        src_reg    = REG_NONE;
        dst_reg    = REG_NONE;
        flag_mask  = '0;
        flag_value = '0;
        case (opcode)
            OP_NOP: op_class = CL_FLAG; // Touches no flag
            OP_SEC: begin
                op_class           = CL_FLAG;
                flag_mask[FLAG_C]  = 1'b1;
                flag_value[FLAG_C] = 1'b1;
            end
            OP_CLC: begin
                op_class          = CL_FLAG;
                flag_mask[FLAG_C] = 1'b1;
            end
            OP_CLV: begin
                op_class          = CL_FLAG;
                flag_mask[FLAG_V] = 1'b1;
            end
            OP_TAX, OP_TAY: begin
                op_class = CL_XFER;
                src_reg  = REG_A;
                dst_reg  = (opcode == OP_TAX) ? REG_X : REG_Y;
            end
            OP_TXA, OP_TYA: begin
                op_class = CL_XFER;
                src_reg  = (opcode == OP_TXA) ? REG_X : REG_Y;
                dst_reg  = REG_A;
            end
            OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A: begin
                op_class  = CL_REG_ALU;
                src_reg   = REG_A;
                dst_reg   = REG_A;
                flag_mask = MASK_CZN; // Shifts also move carry
            end
            OP_INX, OP_DEX, OP_INY, OP_DEY: begin
                op_class  = CL_REG_ALU;
                src_reg   = (opcode == OP_INX || opcode == OP_DEX) ? REG_X : REG_Y;
                dst_reg   = src_reg;
                flag_mask = MASK_ZN;
            end
            OP_LDA_IMM, OP_LDA_ZPG, OP_LDA_ABS,
            OP_LDX_IMM, OP_LDX_ZPG, OP_LDX_ABS,
            OP_LDY_IMM, OP_LDY_ZPG, OP_LDY_ABS: begin
                op_class  = CL_LOAD;
                dst_reg   = REG_A;
                flag_mask = MASK_ZN;
                if (opcode == OP_LDX_IMM || opcode == OP_LDX_ZPG || opcode == OP_LDX_ABS)
                    dst_reg = REG_X;
                if (opcode == OP_LDY_IMM || opcode == OP_LDY_ZPG || opcode == OP_LDY_ABS)
                    dst_reg = REG_Y;
            end
            OP_STA_ZPG, OP_STA_ABS: begin
                op_class = CL_STORE;
                src_reg  = REG_A;
            end
            OP_STX_ZPG, OP_STX_ABS: begin
                op_class = CL_STORE;
                src_reg  = REG_X;
            end
            OP_STY_ZPG, OP_STY_ABS: begin
                op_class = CL_STORE;
                src_reg  = REG_Y;
            end
            OP_AND_ZPG, OP_AND_ABS, OP_ORA_ZPG, OP_ORA_ABS, OP_EOR_ZPG, OP_EOR_ABS,
            OP_ADC_ZPG, OP_ADC_ABS, OP_SBC_ZPG, OP_SBC_ABS: begin
                op_class  = CL_MEM_ALU;
                src_reg   = REG_A;
                dst_reg   = REG_A;
                flag_mask = MASK_ZN;
            end
            OP_JMP_ABS: op_class = CL_JUMP;
            default: ;
        endcase
    end

    always_comb begin
        addr_mode = AM_IMP;
        case (opcode)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: addr_mode = AM_IMM;
            OP_LDA_ZPG, OP_LDX_ZPG, OP_LDY_ZPG, OP_STA_ZPG, OP_STX_ZPG, OP_STY_ZPG,
            OP_AND_ZPG, OP_ORA_ZPG, OP_EOR_ZPG, OP_ADC_ZPG, OP_SBC_ZPG: addr_mode = AM_ZPG;
            OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_STA_ABS, OP_STX_ABS, OP_STY_ABS,
            OP_AND_ABS, OP_ORA_ABS, OP_EOR_ABS, OP_ADC_ABS, OP_SBC_ABS,
            OP_JMP_ABS: addr_mode = AM_ABS;
            default: ;
        endcase
    end

    always_comb begin
        alu_op = ALU_NOP;
        case (opcode)
            OP_ASL_A: alu_op = ALU_ASL;
            OP_LSR_A: alu_op = ALU_LSR;
            OP_ROL_A: alu_op = ALU_ROL;
            OP_ROR_A: alu_op = ALU_ROR;
            OP_INX, OP_INY: alu_op = ALU_INC;
            OP_DEX, OP_DEY: alu_op = ALU_DEC;
            OP_AND_ZPG, OP_AND_ABS: alu_op = ALU_AND;
            OP_ORA_ZPG, OP_ORA_ABS: alu_op = ALU_OR;
            OP_EOR_ZPG, OP_EOR_ABS: alu_op = ALU_XOR;
            OP_ADC_ZPG, OP_ADC_ABS: alu_op = ALU_ADD;
            OP_SBC_ZPG, OP_SBC_ABS: alu_op = ALU_SUB;
            default: if (op_class == CL_LOAD) alu_op = ALU_FLG; // Loads only set Z and N
        endcase
    end

endmodule

/* operand_counter.sv */
`timescale 1ns/1ns

module operand_counter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clk_enable,
    input  logic                                 operand_load,
    input  logic                                 operand_step,
    input  logic [cpu_ctrl_pkg::OPERAND_CNT_W-1:0] load_count,
    output logic                                 operand_last
);
    import cpu_ctrl_pkg::*;

    logic [OPERAND_CNT_W-1:0] count; // Operand bytes still to fetch

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clk_enable) begin
            if (operand_load) begin
                count <= load_count;
            end else if (operand_step && count != '0) begin
                count <= count - 1'b1;
            end
        end
    end

    assign operand_last = (count == OPERAND_CNT_W'(1));

endmodule

/* operand_address_reg.sv */
`timescale 1ns/1ns

module operand_address_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_enable,
    input  logic                          capture_low,
    input  logic                          capture_high,
    input  cpu_isa_pkg::opcode_t          instruction,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] memory_address
);
    import cpu_ctrl_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memory_address <= '0;
        end else if (clk_enable) begin
            if (capture_low) begin
                memory_address <= {{(ADDR_W - 8){1'b0}}, instruction}; // Zero page until a high byte
            end else if (capture_high) begin
                memory_address[ADDR_W-1:8] <= instruction;
            end
        end
    end

endmodule

/* decode_fsm.sv */
`timescale 1ns/1ns

module decode_fsm (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clk_enable,
    input  cpu_isa_pkg::addr_mode_t               addr_mode,
    input  cpu_isa_pkg::op_class_t                op_class,
    input  cpu_isa_pkg::reg_sel_t                 src_reg,
    input  cpu_isa_pkg::reg_sel_t                 dst_reg,
    input  cpu_isa_pkg::alu_op_t                  alu_op,
    input  cpu_isa_pkg::flag_mask_t               flag_mask,
    input  cpu_isa_pkg::flag_mask_t               flag_value,
    input  logic                                  operand_last,
    output logic                                  capture_opcode,
    output logic                                  operand_load,
    output logic                                  operand_step,
    output logic                                  capture_low,
    output logic                                  capture_high,
    output logic [cpu_ctrl_pkg::OPERAND_CNT_W-1:0] load_count,
    output cpu_isa_pkg::flag_mask_t               psr_write,
    output cpu_isa_pkg::flag_mask_t               psr_value,
    output logic                                  psr_rw,
    output cpu_ctrl_pkg::addr_sel_t               address_select,
    output logic                                  rw,
    output cpu_ctrl_pkg::buf2_t                   data_buffer_enable,
    output cpu_ctrl_pkg::buf2_t                   input_data_latch_enable,
    output cpu_ctrl_pkg::pc_ctrl_t                pc_enable,
    output cpu_isa_pkg::alu_op_t                  alu_enable,
    output cpu_ctrl_pkg::buf3_t                   accumulator_enable,
    output cpu_ctrl_pkg::buf3_t                   index_x_enable,
    output cpu_ctrl_pkg::buf3_t                   index_y_enable
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    fsm_state_t state;
    fsm_state_t next_state;
    reg_sel_t   slot_a_reg; // At most two registers are strobed per cycle
    reg_sel_t   slot_b_reg;
    buf3_t      slot_a_val;
    buf3_t      slot_b_val;
    logic       needs_operand;

    function automatic buf3_t reg_strobe(reg_sel_t who, reg_sel_t a_reg, buf3_t a_val,
                                         reg_sel_t b_reg, buf3_t b_val);
        if (who == a_reg)
            return a_val;
        if (who == b_reg)
            return b_val;
        return BUF3_IDLE;
    endfunction

    assign needs_operand  = (addr_mode == AM_ZPG) || (addr_mode == AM_ABS);
    assign capture_opcode = (state == S_IDLE);
    assign operand_load   = (state == S_OPCODE_READ) && needs_operand;
    assign capture_low    = operand_load;
    assign operand_step   = (state == S_OPERAND_FETCH);
    assign capture_high   = operand_step && !operand_last;
    assign load_count     = (addr_mode == AM_ZPG) ? OPERAND_CNT_W'(1) : OPERAND_CNT_W'(2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (clk_enable) begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state              = S_IDLE;
        psr_write               = '0;
        psr_value               = '0;
        psr_rw                  = 1'b1;
        address_select          = ADDR_PC;
        rw                      = 1'b1;
        data_buffer_enable      = BUF2_IDLE;
        input_data_latch_enable = BUF2_IDLE;
        pc_enable               = PC_HOLD;
        alu_enable              = ALU_NOP;
        slot_a_reg              = REG_NONE;
        slot_a_val              = BUF3_IDLE;
        slot_b_reg              = REG_NONE;
        slot_b_val              = BUF3_IDLE;
        case (state)
            S_IDLE: next_state = S_OPCODE_READ;
            S_OPCODE_READ: begin
                pc_enable = PC_INC;
                case (op_class)
                    CL_FLAG: begin
                        psr_write = flag_mask;
                        psr_value = flag_value;
                    end
                    CL_XFER: begin
                        slot_a_reg = src_reg;
                        slot_a_val = BUF3_STORE1;
                        slot_b_reg = dst_reg;
                        slot_b_val = BUF3_LOAD1;
                    end
                    CL_REG_ALU: next_state = S_ALU_FINAL;
                    CL_LOAD: next_state = needs_operand ? S_OPERAND_FETCH : S_DATA_LATCH;
                    CL_STORE, CL_MEM_ALU, CL_JUMP: next_state = S_OPERAND_FETCH;
                    default: ; // Unknown opcodes retire here
                endcase
            end
            S_OPERAND_FETCH: begin
                pc_enable = PC_INC;
                if (!operand_last)
                    next_state = S_OPERAND_FETCH;
                else if (op_class == CL_JUMP)
                    next_state = S_PC_LOAD;
                else if (op_class == CL_STORE)
                    next_state = S_ALU_TMX;
                else
                    next_state = S_DATA_LATCH;
            end
            S_DATA_LATCH: begin
                input_data_latch_enable = BUF2_LOAD;
                address_select          = ADDR_MEM;
                next_state              = S_ALU_FINAL;
            end
            S_ALU_FINAL: begin
                psr_rw     = 1'b0;
                alu_enable = alu_op;
                psr_write  = flag_mask;
                next_state = S_ALU_TMX;
                if (op_class == CL_REG_ALU) begin
                    slot_a_reg = src_reg;
                    slot_a_val = BUF3_STORE1;
                end else begin
                    input_data_latch_enable = BUF2_STORE; // Memory operand from the latch
                    if (op_class == CL_MEM_ALU) begin
                        slot_a_reg = REG_A;
                        slot_a_val = BUF3_STORE2;
                    end
                end
            end
            S_ALU_TMX: begin
                if (op_class == CL_STORE) begin
                    slot_a_reg         = src_reg;
                    slot_a_val         = BUF3_STORE2;
                    data_buffer_enable = BUF2_LOAD;
                    next_state         = S_DBUF_OUTPUT;
                end else begin
                    alu_enable = ALU_TMX;
                    slot_a_reg = dst_reg;
                    slot_a_val = BUF3_LOAD2;
                end
            end
            S_DBUF_OUTPUT: begin
                data_buffer_enable = BUF2_STORE;
                rw                 = 1'b0;
                address_select     = ADDR_MEM;
            end
            S_PC_LOAD: begin
                pc_enable      = PC_LOAD;
                address_select = ADDR_MEM;
            end
            default: ;
        endcase
    end

    assign accumulator_enable = reg_strobe(REG_A, slot_a_reg, slot_a_val, slot_b_reg, slot_b_val);
    assign index_x_enable     = reg_strobe(REG_X, slot_a_reg, slot_a_val, slot_b_reg, slot_b_val);
    assign index_y_enable     = reg_strobe(REG_Y, slot_a_reg, slot_a_val, slot_b_reg, slot_b_val);

endmodule

/* cpu_decode_top.sv */
`timescale 1ns/1ns

module cpu_decode_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clk_enable,
    input  cpu_isa_pkg::opcode_t          instruction,
    output cpu_isa_pkg::flag_mask_t       psr_write,
    output cpu_isa_pkg::flag_mask_t       psr_value,
    output logic                          psr_rw,
    output logic [cpu_ctrl_pkg::ADDR_W-1:0] memory_address,
    output cpu_ctrl_pkg::addr_sel_t       address_select,
    output logic                          rw,
    output cpu_ctrl_pkg::buf2_t           data_buffer_enable,
    output cpu_ctrl_pkg::buf2_t           input_data_latch_enable,
    output cpu_ctrl_pkg::pc_ctrl_t        pc_enable,
    output cpu_isa_pkg::alu_op_t          alu_enable,
    output cpu_ctrl_pkg::buf3_t           accumulator_enable,
    output cpu_ctrl_pkg::buf3_t           index_x_enable,
    output cpu_ctrl_pkg::buf3_t           index_y_enable
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    addr_mode_t               addr_mode;
    op_class_t                op_class;
    reg_sel_t                 src_reg;
    reg_sel_t                 dst_reg;
    alu_op_t                  alu_op;
    flag_mask_t               flag_mask;
    flag_mask_t               flag_value;
    logic                     capture_opcode;
    logic                     operand_load;
    logic                     operand_step;
    logic                     operand_last;
    logic                     capture_low;
    logic                     capture_high;
    logic [OPERAND_CNT_W-1:0] load_count;

    opcode_decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable),
        .capture_opcode(capture_opcode), .instruction(instruction),
        .addr_mode(addr_mode), .op_class(op_class), .src_reg(src_reg), .dst_reg(dst_reg),
        .alu_op(alu_op), .flag_mask(flag_mask), .flag_value(flag_value)
    );

    operand_counter u_counter (
        .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable),
        .operand_load(operand_load), .operand_step(operand_step),
        .load_count(load_count), .operand_last(operand_last)
    );

    operand_address_reg u_address (
        .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable),
        .capture_low(capture_low), .capture_high(capture_high),
        .instruction(instruction), .memory_address(memory_address)
    );

    decode_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable),
        .addr_mode(addr_mode), .op_class(op_class), .src_reg(src_reg), .dst_reg(dst_reg),
        .alu_op(alu_op), .flag_mask(flag_mask), .flag_value(flag_value),
        .operand_last(operand_last), .capture_opcode(capture_opcode),
        .operand_load(operand_load), .operand_step(operand_step),
        .capture_low(capture_low), .capture_high(capture_high), .load_count(load_count),
        .psr_write(psr_write), .psr_value(psr_value), .psr_rw(psr_rw),
        .address_select(address_select), .rw(rw),
        .data_buffer_enable(data_buffer_enable),
        .input_data_latch_enable(input_data_latch_enable),
        .pc_enable(pc_enable), .alu_enable(alu_enable),
        .accumulator_enable(accumulator_enable),
        .index_x_enable(index_x_enable), .index_y_enable(index_y_enable)
    );

endmodule

/* cpu_decode_checker.sv */
`timescale 1ns/1ns

module cpu_decode_checker (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_isa_pkg::flag_mask_t psr_write,
    input  logic                    psr_rw,
    input  logic                    rw,
    input  cpu_ctrl_pkg::addr_sel_t address_select,
    input  cpu_ctrl_pkg::buf2_t     data_buffer_enable,
    input  cpu_ctrl_pkg::buf2_t     input_data_latch_enable,
    input  cpu_ctrl_pkg::pc_ctrl_t  pc_enable,
    input  cpu_isa_pkg::alu_op_t    alu_enable,
    input  cpu_ctrl_pkg::buf3_t     accumulator_enable,
    input  cpu_ctrl_pkg::buf3_t     index_x_enable,
    input  cpu_ctrl_pkg::buf3_t     index_y_enable
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    int failures = 0; // Polled by the testbench

    function automatic logic is_load(buf3_t strobe);
        return (strobe == BUF3_LOAD1) || (strobe == BUF3_LOAD2);
    endfunction

    // A memory write always comes from the data buffer at the operand address
    write_path: assert property (@(posedge clk) disable iff (!rst_n)
        !rw |-> (data_buffer_enable == BUF2_STORE) && (address_select == ADDR_MEM))
    else begin
        failures++;
        $error("rw low without data buffer STORE on the memory address");
    end

    jump_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !((pc_enable == PC_LOAD) && !rw))
    else begin
        failures++;
        $error("pc_enable LOAD in the same cycle as a memory write");
    end

    single_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(is_load(accumulator_enable) && (is_load(index_x_enable) || is_load(index_y_enable))))
    else begin
        failures++;
        $error("accumulator and an index register load together");
    end

    reset_idle: assert property (@(posedge clk)
        !rst_n |-> (psr_write == '0) && psr_rw && rw && (pc_enable == PC_HOLD)
            && (data_buffer_enable == BUF2_IDLE) && (input_data_latch_enable == BUF2_IDLE)
            && (alu_enable == ALU_NOP) && (accumulator_enable == BUF3_IDLE)
            && (index_x_enable == BUF3_IDLE) && (index_y_enable == BUF3_IDLE))
    else begin
        failures++;
        $error("a control strobe is active during reset");
    end

endmodule

bind cpu_decode_top cpu_decode_checker checker_i (.*);

/* tb_cpu_decode.sv */
`timescale 1ns/1ns

module tb_cpu_decode;
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 3;
    localparam int TRACE_FIELDS = 15;

    typedef struct packed {
        logic [7:0]  instr;
        logic        en;
        logic [7:0]  psr_write;
        logic [7:0]  psr_value;
        logic        psr_rw;
        logic [15:0] memory_address;
        logic [1:0]  address_select;
        logic        rw;
        logic [1:0]  data_buffer_enable;
        logic [1:0]  input_data_latch_enable;
        logic [1:0]  pc_enable;
        logic [4:0]  alu_enable;
        logic [2:0]  accumulator_enable;
        logic [2:0]  index_x_enable;
        logic [2:0]  index_y_enable;
    } trace_row_t;

    logic              clk;
    logic              rst_n;
    logic              clk_enable;
    opcode_t           instruction;
    flag_mask_t        psr_write;
    flag_mask_t        psr_value;
    logic              psr_rw;
    logic [ADDR_W-1:0] memory_address;
    addr_sel_t         address_select;
    logic              rw;
    buf2_t             data_buffer_enable;
    buf2_t             input_data_latch_enable;
    pc_ctrl_t          pc_enable;
    alu_op_t           alu_enable;
    buf3_t             accumulator_enable;
    buf3_t             index_x_enable;
    buf3_t             index_y_enable;

    trace_row_t trace_rows [$];
    bit         trace_ready;

    cpu_decode_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic load_trace(output string problem);
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        int unsigned v [TRACE_FIELDS];
        trace_row_t  row;
        problem = "";
        line_no = 0;
        fd = $fopen("cpu_decode_trace.txt", "r");
        if (fd == 0) begin
            problem = "could not open cpu_decode_trace.txt";
            return;
        end
        while (!$feof(fd) && problem == "") begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if (line.len() > 0 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                 v[8], v[9], v[10], v[11], v[12], v[13], v[14]);
                if (fields == TRACE_FIELDS) begin
                    row.instr                   = 8'(v[0]);
                    row.en                      = 1'(v[1]);
                    row.psr_write               = 8'(v[2]);
                    row.psr_value               = 8'(v[3]);
                    row.psr_rw                  = 1'(v[4]);
                    row.memory_address          = 16'(v[5]);
                    row.address_select          = 2'(v[6]);
                    row.rw                      = 1'(v[7]);
                    row.data_buffer_enable      = 2'(v[8]);
                    row.input_data_latch_enable = 2'(v[9]);
                    row.pc_enable               = 2'(v[10]);
                    row.alu_enable              = 5'(v[11]);
                    row.accumulator_enable      = 3'(v[12]);
                    row.index_x_enable          = 3'(v[13]);
                    row.index_y_enable          = 3'(v[14]);
                    trace_rows.push_back(row);
                end else if (fields > 0) begin
                    problem = $sformatf("trace line %0d has %0d fields, expected %0d",
                                        line_no, fields, TRACE_FIELDS);
                end
            end
        end
        $fclose(fd);
        if (problem == "" && trace_rows.size() == 0)
            problem = "the trace file holds no cycles";
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected, input int row_idx);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h (trace row %0d)",
                     $time, name, expected, actual, row_idx);
            abort_run("DUT output differs from the trace");
        end
    endtask

    task automatic compare_outputs(input int row_idx);
        trace_row_t exp;
        exp = trace_rows[row_idx];
        check_value("psr_write", psr_write, exp.psr_write, row_idx);
        check_value("psr_value", psr_value, exp.psr_value, row_idx);
        check_value("psr_rw", psr_rw, exp.psr_rw, row_idx);
        check_value("memory_address", memory_address, exp.memory_address, row_idx);
        check_value("address_select", address_select, exp.address_select, row_idx);
        check_value("rw", rw, exp.rw, row_idx);
        check_value("data_buffer_enable", data_buffer_enable, exp.data_buffer_enable, row_idx);
        check_value("input_data_latch_enable", input_data_latch_enable,
                    exp.input_data_latch_enable, row_idx);
        check_value("pc_enable", pc_enable, exp.pc_enable, row_idx);
        check_value("alu_enable", alu_enable, exp.alu_enable, row_idx);
        check_value("accumulator_enable", accumulator_enable, exp.accumulator_enable, row_idx);
        check_value("index_x_enable", index_x_enable, exp.index_x_enable, row_idx);
        check_value("index_y_enable", index_y_enable, exp.index_y_enable, row_idx);
    endtask

    initial begin
        string problem;
        rst_n       = 1'b0;
        clk_enable  = 1'b0;
        instruction = OP_NOP;
        load_trace(problem);
        if (problem != "") begin
            abort_run(problem);
        end else begin
            trace_ready = 1'b1;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst_n = 1'b1;
            foreach (trace_rows[i]) begin
                instruction = trace_rows[i].instr;
                clk_enable  = trace_rows[i].en;
                #(CLK_PERIOD - 2); // Just before the edge that consumes this row
                compare_outputs(i);
                assert (dut_i.checker_i.failures == 0) else
                    abort_run("a bound assertion on the control outputs failed");
                @(posedge clk);
                #1;
            end
            if (dut_i.checker_i.failures == 0) begin
                $display("Test passed");
                $finish;
            end else begin
                abort_run("a bound assertion on the control outputs failed");
            end
        end
    end

    // One clock period per trace row plus margin for reset
    initial begin
        wait (trace_ready);
        #(trace_rows.size() * CLK_PERIOD + 100);
        abort_run("watchdog expired before the trace was finished");
    end

endmodule

/* cpu_decode_trace.txt */
# instr en psr_write psr_value psr_rw mem_addr addr_sel rw dbuf latch pc alu acc x y
# All hex, one row per clock cycle from reset release, outputs sampled before the next edge
38 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
00 1 01 01 1 0000 0 1 0 0 1 00 0 0 0
18 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
00 1 01 00 1 0000 0 1 0 0 1 00 0 0 0
b8 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
00 1 40 00 1 0000 0 1 0 0 1 00 0 0 0
aa 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
00 1 00 00 1 0000 0 1 0 0 1 00 4 6 0
8a 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
00 1 00 00 1 0000 0 1 0 0 1 00 6 4 0
a9 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
55 1 00 00 1 0000 0 1 0 0 1 00 0 0 0
00 1 00 00 1 0000 1 1 0 1 0 00 0 0 0
00 1 82 00 0 0000 0 1 0 2 0 0c 0 0 0
00 1 00 00 1 0000 0 1 0 0 0 0d 7 0 0
a6 1 00 00 1 0000 0 1 0 0 0 00 0 0 0
42 1 00 00 1 0000 0 1 0 0 1 00 0 0 0
00 1 00 00 1 0042 0 1 0 0 1 00 0 0 0
00 1 00 00 1 0042 1 1 0 1 0 00 0 0 0
00 1 82 00 0 0042 0 1 0 2 0 0c 0 0 0
00 1 00 00 1 0042 0 1 0 0 0 0d 0 7 0
8d 1 00 00 1 0042 0 1 0 0 0 00 0 0 0
34 1 00 00 1 0042 0 1 0 0 1 00 0 0 0
12 1 00 00 1 0034 0 1 0 0 1 00 0 0 0
00 1 00 00 1 1234 0 1 0 0 1 00 0 0 0
00 1 00 00 1 1234 0 1 1 0 0 00 5 0 0
00 1 00 00 1 1234 1 0 2 0 0 00 0 0 0
65 1 00 00 1 1234 0 1 0 0 0 00 0 0 0
80 1 00 00 1 1234 0 1 0 0 1 00 0 0 0
00 1 00 00 1 0080 0 1 0 0 1 00 0 0 0
00 1 00 00 1 0080 1 1 0 1 0 00 0 0 0
00 1 82 00 0 0080 0 1 0 2 0 08 5 0 0
00 1 00 00 1 0080 0 1 0 0 0 0d 7 0 0
2a 1 00 00 1 0080 0 1 0 0 0 00 0 0 0
00 1 00 00 1 0080 0 1 0 0 1 00 0 0 0
00 1 83 00 0 0080 0 1 0 0 0 03 4 0 0
00 1 00 00 1 0080 0 1 0 0 0 0d 7 0 0
4c 1 00 00 1 0080 0 1 0 0 0 00 0 0 0
00 1 00 00 1 0080 0 1 0 0 1 00 0 0 0
c0 1 00 00 1 0000 0 1 0 0 1 00 0 0 0
00 1 00 00 1 c000 0 1 0 0 1 00 0 0 0
00 1 00 00 1 c000 1 1 0 0 2 00 0 0 0
ac 1 00 00 1 c000 0 1 0 0 0 00 0 0 0
78 1 00 00 1 c000 0 1 0 0 1 00 0 0 0
99 0 00 00 1 0078 0 1 0 0 1 00 0 0 0
99 0 00 00 1 0078 0 1 0 0 1 00 0 0 0
56 1 00 00 1 0078 0 1 0 0 1 00 0 0 0
00 1 00 00 1 5678 0 1 0 0 1 00 0 0 0
00 1 00 00 1 5678 1 1 0 1 0 00 0 0 0
00 1 82 00 0 5678 0 1 0 2 0 0c 0 0 0
00 1 00 00 1 5678 0 1 0 0 0 0d 0 0 7

/* tb.f */
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
opcode_decoder.sv
operand_counter.sv
operand_address_reg.sv
decode_fsm.sv
cpu_decode_top.sv
cpu_decode_checker.sv
tb_cpu_decode.sv
